// File: hdl/ucaspian_link_pkg.sv
// Shared types and constants for the host packet link.
// Host links carry one byte per transfer. Network time width must be a multiple of 8.
`default_nettype none

package ucaspian_link_pkg;

    // one byte on either host link
    typedef logic [7:0] pkt_byte_t;

    // host to core opcodes
    localparam pkt_byte_t OP_STEP    = 8'h01;
    localparam pkt_byte_t OP_METRIC  = 8'h02;
    localparam pkt_byte_t OP_CLR_ACT = 8'h04;
    localparam pkt_byte_t OP_CLR_CFG = 8'h05;

    // set in the opcode of an input fire, low bits are the fire address
    localparam int FIRE_FLAG_BIT = 7;

    // core to host packet headers
    localparam pkt_byte_t TX_HDR_TIME   = 8'h01;
    localparam pkt_byte_t TX_HDR_FIRE   = 8'h80;
    localparam pkt_byte_t TX_HDR_METRIC = 8'h02;
    localparam pkt_byte_t TX_HDR_CLEAR  = 8'h04;

    // host-bound response kinds
    typedef enum logic [1:0] {
        RESP_TIME,
        RESP_FIRE,
        RESP_METRIC,
        RESP_CLEAR
    } resp_kind_t;

    // packet lengths in bytes, header included
    localparam int LEN_FIRE   = 2;
    localparam int LEN_METRIC = 3;
    localparam int LEN_CLEAR  = 1;

    localparam int TIME_W_DEFAULT = 32;

endpackage

`default_nettype wire

// File: hdl/packet_rx_parser.sv
// Host command parser. Expects rx_byte_take to already include valid and the
// gated ready. One request to the core is pending at a time; no bytes are taken
// until it is acknowledged. Unknown opcodes without the fire flag are dropped.
`timescale 1ns/100ps
`default_nettype none

module packet_rx_parser (
    input  logic                         clk,
    input  logic                         reset,
    input  ucaspian_link_pkg::pkt_byte_t rx_packet_data,
    input  bit                           rx_byte_take,
    input  logic                         input_fire_ack,
    input  logic                         time_target_ack,
    input  logic                         metric_sent,
    input  logic                         ack_sent,
    output logic                         rx_ready,
    output ucaspian_link_pkg::pkt_byte_t input_fire_addr,
    output ucaspian_link_pkg::pkt_byte_t input_fire_value,
    output logic                         input_fire_waiting,
    output ucaspian_link_pkg::pkt_byte_t time_target_value,
    output logic                         time_target_waiting,
    output ucaspian_link_pkg::pkt_byte_t metric_addr,
    output logic                         metric_read,
    output logic                         clear_act,
    output logic                         clear_config,
    output logic                         led
);

    typedef enum logic [2:0] {
        RX_IDLE,
        RX_FIRE,
        RX_STEP,
        RX_METRIC,
        RX_CLR_ACT,
        RX_CLR_CFG
    } rx_state_t;

    rx_state_t state;

    // clear states take no operand, other states wait for their request to finish
    assign rx_ready = (state != RX_CLR_ACT) && (state != RX_CLR_CFG) &&
                      !input_fire_waiting && !time_target_waiting && !metric_read;

    assign led = (state == RX_IDLE);

    always_ff @(posedge clk) begin
        if (reset) begin
            state               <= RX_IDLE;
            input_fire_waiting  <= 1'b0;
            time_target_waiting <= 1'b0;
            metric_read         <= 1'b0;
            clear_act           <= 1'b0;
            clear_config        <= 1'b0;
        end else begin
            case (state)
                RX_IDLE: begin
                    if (rx_byte_take) begin
                        if (rx_packet_data[ucaspian_link_pkg::FIRE_FLAG_BIT]) begin
                            state <= RX_FIRE;
                        end else begin
                            case (rx_packet_data)
                                ucaspian_link_pkg::OP_STEP:   state <= RX_STEP;
                                ucaspian_link_pkg::OP_METRIC: state <= RX_METRIC;
                                ucaspian_link_pkg::OP_CLR_ACT: begin
                                    state     <= RX_CLR_ACT;
                                    clear_act <= 1'b1;
                                end
                                ucaspian_link_pkg::OP_CLR_CFG: begin
                                    state        <= RX_CLR_CFG;
                                    clear_config <= 1'b1;
                                end
                                // unknown opcode, drop it
                                default: state <= RX_IDLE;
                            endcase
                        end
                    end
                end
                RX_FIRE: begin
                    if (input_fire_waiting) begin
                        if (input_fire_ack) begin
                            input_fire_waiting <= 1'b0;
                            state              <= RX_IDLE;
                        end
                    end else if (rx_byte_take) begin
                        input_fire_waiting <= 1'b1;
                    end
                end
                RX_STEP: begin
                    if (time_target_waiting) begin
                        if (time_target_ack) begin
                            time_target_waiting <= 1'b0;
                            state               <= RX_IDLE;
                        end
                    end else if (rx_byte_take) begin
                        time_target_waiting <= 1'b1;
                    end
                end
                RX_METRIC: begin
                    // released once the metric packet has left
                    if (metric_read) begin
                        if (metric_sent) begin
                            metric_read <= 1'b0;
                            state       <= RX_IDLE;
                        end
                    end else if (rx_byte_take) begin
                        metric_read <= 1'b1;
                    end
                end
                RX_CLR_ACT: begin
                    if (ack_sent) begin
                        clear_act <= 1'b0;
                        state     <= RX_IDLE;
                    end
                end
                RX_CLR_CFG: begin
                    if (ack_sent) begin
                        clear_config <= 1'b0;
                        state        <= RX_IDLE;
                    end
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    // operand capture, held steady while the request is pending
    always_ff @(posedge clk) begin
        if (rx_byte_take) begin
            case (state)
                RX_IDLE: input_fire_addr <=
                    {1'b0, rx_packet_data[ucaspian_link_pkg::FIRE_FLAG_BIT-1:0]};
                RX_FIRE:   input_fire_value  <= rx_packet_data;
                RX_STEP:   time_target_value <= rx_packet_data;
                RX_METRIC: metric_addr       <= rx_packet_data;
                default: ;
            endcase
        end
    end

    // fire and step share one parser, so at most one can be in front of the core
    assert property (@(posedge clk) disable iff (reset)
        !(input_fire_waiting && time_target_waiting));

endmodule

`default_nettype wire

// File: hdl/tx_response_select.sv
// Picks the next host-bound response in fixed priority, one in flight at a time.
// Requesters must drop their request within one cycle of the sent strobe.
`timescale 1ns/100ps
`default_nettype none

module tx_response_select (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          time_update,
    input  logic                          time_remaining,
    input  logic                          output_fire_waiting,
    input  logic                          metric_send,
    input  logic                          clear_done,
    input  logic                          resp_done,
    output logic                          resp_start,
    output ucaspian_link_pkg::resp_kind_t resp_kind,
    output logic                          time_sent,
    output logic                          output_fire_sent,
    output logic                          metric_sent,
    output logic                          ack_sent
);

    logic in_flight;
    logic holdoff;
    logic sent_any;
    logic arb_en;
    logic req_time;
    logic req_any;
    ucaspian_link_pkg::resp_kind_t next_kind;

    always_comb begin
        // a pending output fire lets the time report through early
        req_time = time_update && (!time_remaining || output_fire_waiting);
        req_any  = req_time || output_fire_waiting || metric_send || clear_done;
        if (req_time) begin
            next_kind = ucaspian_link_pkg::RESP_TIME;
        end else if (output_fire_waiting) begin
            next_kind = ucaspian_link_pkg::RESP_FIRE;
        end else if (metric_send) begin
            next_kind = ucaspian_link_pkg::RESP_METRIC;
        end else begin
            next_kind = ucaspian_link_pkg::RESP_CLEAR;
        end
    end

    assign sent_any = time_sent || output_fire_sent || metric_sent || ack_sent;
    assign arb_en   = !in_flight && !sent_any && !holdoff;

    always_ff @(posedge clk) begin
        if (reset) begin
            resp_start       <= 1'b0;
            in_flight        <= 1'b0;
            holdoff          <= 1'b0;
            time_sent        <= 1'b0;
            output_fire_sent <= 1'b0;
            metric_sent      <= 1'b0;
            ack_sent         <= 1'b0;
        end else begin
            resp_start <= arb_en && req_any;
            if (arb_en && req_any) begin
                in_flight <= 1'b1;
            end else if (resp_done) begin
                in_flight <= 1'b0;
            end
            time_sent        <= resp_done && (resp_kind == ucaspian_link_pkg::RESP_TIME);
            output_fire_sent <= resp_done && (resp_kind == ucaspian_link_pkg::RESP_FIRE);
            metric_sent      <= resp_done && (resp_kind == ucaspian_link_pkg::RESP_METRIC);
            ack_sent         <= resp_done && (resp_kind == ucaspian_link_pkg::RESP_CLEAR);
            // one quiet cycle after a sent strobe
            holdoff          <= sent_any;
        end
    end

    // kind stays put while in flight, used to route the sent strobe
    always_ff @(posedge clk) begin
        if (arb_en && req_any) begin
            resp_kind <= next_kind;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        resp_start |-> !$past(in_flight));

endmodule

`default_nettype wire

// File: hdl/tx_serializer.sv
// Sends one host-bound packet per resp_start, header first, time bytes MSB first.
// TIME_W must be a multiple of 8. Metric address and value are sampled as their
// bytes are loaded, so they must stay valid until resp_done.
`timescale 1ns/100ps
`default_nettype none

module tx_serializer #(
    parameter int TIME_W = 32
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          resp_start,
    input  ucaspian_link_pkg::resp_kind_t resp_kind,
    input  logic [TIME_W-1:0]             time_current,
    input  ucaspian_link_pkg::pkt_byte_t  output_fire_addr,
    input  ucaspian_link_pkg::pkt_byte_t  metric_addr,
    input  ucaspian_link_pkg::pkt_byte_t  metric_value,
    input  logic                          tx_packet_rdy,
    output ucaspian_link_pkg::pkt_byte_t  tx_packet_data,
    output logic                          tx_packet_vld,
    output logic                          resp_done
);

    localparam int NBYTES = TIME_W / 8;
    localparam int CNT_W  = $clog2(NBYTES + 2);

    logic                          busy;
    logic [CNT_W-1:0]              load_cnt;
    logic [CNT_W-1:0]              pkt_len;
    logic [CNT_W-1:0]              start_len;
    logic [TIME_W-1:0]             time_shift;
    ucaspian_link_pkg::resp_kind_t kind_q;
    ucaspian_link_pkg::pkt_byte_t  fire_addr_q;
    ucaspian_link_pkg::pkt_byte_t  hdr_byte;
    ucaspian_link_pkg::pkt_byte_t  next_byte;
    logic                          load_next;
    logic                          finish;

    // header and length straight from the strobe so byte 0 goes out next cycle
    always_comb begin
        case (resp_kind)
            ucaspian_link_pkg::RESP_TIME: begin
                hdr_byte  = ucaspian_link_pkg::TX_HDR_TIME;
                start_len = CNT_W'(NBYTES + 1);
            end
            ucaspian_link_pkg::RESP_FIRE: begin
                hdr_byte  = ucaspian_link_pkg::TX_HDR_FIRE;
                start_len = CNT_W'(ucaspian_link_pkg::LEN_FIRE);
            end
            ucaspian_link_pkg::RESP_METRIC: begin
                hdr_byte  = ucaspian_link_pkg::TX_HDR_METRIC;
                start_len = CNT_W'(ucaspian_link_pkg::LEN_METRIC);
            end
            default: begin
                hdr_byte  = ucaspian_link_pkg::TX_HDR_CLEAR;
                start_len = CNT_W'(ucaspian_link_pkg::LEN_CLEAR);
            end
        endcase
    end

    always_comb begin
        case (kind_q)
            ucaspian_link_pkg::RESP_FIRE:   next_byte = fire_addr_q;
            ucaspian_link_pkg::RESP_METRIC: next_byte = (load_cnt == 1) ? metric_addr
                                                                        : metric_value;
            default:                        next_byte = time_shift[TIME_W-1 -: 8];
        endcase
    end

    // valid stays high for the whole packet, so ready alone moves it on
    assign load_next = busy && tx_packet_rdy && (load_cnt != pkt_len);
    assign finish    = busy && tx_packet_rdy && (load_cnt == pkt_len);

    always_ff @(posedge clk) begin
        if (reset) begin
            busy          <= 1'b0;
            tx_packet_vld <= 1'b0;
            resp_done     <= 1'b0;
            load_cnt      <= '0;
        end else begin
            resp_done <= finish;
            if (resp_start) begin
                busy          <= 1'b1;
                tx_packet_vld <= 1'b1;
                load_cnt      <= CNT_W'(1);
            end else if (load_next) begin
                load_cnt <= load_cnt + 1'b1;
            end else if (finish) begin
                busy          <= 1'b0;
                tx_packet_vld <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (resp_start) begin
            kind_q         <= resp_kind;
            pkt_len        <= start_len;
            time_shift     <= time_current;
            fire_addr_q    <= output_fire_addr;
            tx_packet_data <= hdr_byte;
        end else if (load_next) begin
            tx_packet_data <= next_byte;
            time_shift     <= time_shift << 8;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        tx_packet_vld && !tx_packet_rdy |=> tx_packet_vld && $stable(tx_packet_data));

endmodule

`default_nettype wire

// File: hdl/packet_interface.sv
// Host packet link top. Host bytes are held off while network time is moving
// or a time update is pending. Neuron and synapse configuration are not supported.
`timescale 1ns/100ps
`default_nettype none

module packet_interface #(
    parameter int TIME_W = ucaspian_link_pkg::TIME_W_DEFAULT
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         core_active,
    output logic                         ack_sent,
    output logic                         led,
    output logic                         clear_act,
    output logic                         clear_config,
    input  logic                         clear_done,
    input  logic                         time_remaining,
    input  logic [TIME_W-1:0]            time_current,
    input  logic                         time_update,
    output logic                         time_sent,
    output ucaspian_link_pkg::pkt_byte_t time_target_value,
    output logic                         time_target_waiting,
    input  logic                         time_target_ack,
    input  ucaspian_link_pkg::pkt_byte_t output_fire_addr,
    input  logic                         output_fire_waiting,
    output logic                         output_fire_sent,
    output ucaspian_link_pkg::pkt_byte_t input_fire_addr,
    output ucaspian_link_pkg::pkt_byte_t input_fire_value,
    output logic                         input_fire_waiting,
    input  logic                         input_fire_ack,
    output ucaspian_link_pkg::pkt_byte_t metric_addr,
    input  ucaspian_link_pkg::pkt_byte_t metric_value,
    output logic                         metric_read,
    input  logic                         metric_send,
    input  ucaspian_link_pkg::pkt_byte_t rx_packet_data,
    input  logic                         rx_packet_vld,
    output logic                         rx_packet_rdy,
    output ucaspian_link_pkg::pkt_byte_t tx_packet_data,
    output logic                         tx_packet_vld,
    input  logic                         tx_packet_rdy
);

    logic                          parser_rdy;
    logic                          rx_byte_take;
    logic                          metric_sent;
    logic                          resp_start;
    logic                          resp_done;
    ucaspian_link_pkg::resp_kind_t resp_kind;

    // no new commands while time runs or a time report is due
    assign rx_packet_rdy = parser_rdy && !time_remaining && !time_update;
    assign rx_byte_take  = rx_packet_rdy && rx_packet_vld;

    packet_rx_parser u_rx_parser (
        .clk                 (clk),
        .reset               (reset),
        .rx_packet_data      (rx_packet_data),
        .rx_byte_take        (rx_byte_take),
        .input_fire_ack      (input_fire_ack),
        .time_target_ack     (time_target_ack),
        .metric_sent         (metric_sent),
        .ack_sent            (ack_sent),
        .rx_ready            (parser_rdy),
        .input_fire_addr     (input_fire_addr),
        .input_fire_value    (input_fire_value),
        .input_fire_waiting  (input_fire_waiting),
        .time_target_value   (time_target_value),
        .time_target_waiting (time_target_waiting),
        .metric_addr         (metric_addr),
        .metric_read         (metric_read),
        .clear_act           (clear_act),
        .clear_config        (clear_config),
        .led                 (led)
    );

    tx_response_select u_tx_select (
        .clk                 (clk),
        .reset               (reset),
        .time_update         (time_update),
        .time_remaining      (time_remaining),
        .output_fire_waiting (output_fire_waiting),
        .metric_send         (metric_send),
        .clear_done          (clear_done),
        .resp_done           (resp_done),
        .resp_start          (resp_start),
        .resp_kind           (resp_kind),
        .time_sent           (time_sent),
        .output_fire_sent    (output_fire_sent),
        .metric_sent         (metric_sent),
        .ack_sent            (ack_sent)
    );

    tx_serializer #(
        .TIME_W (TIME_W)
    ) u_tx_serializer (
        .clk              (clk),
        .reset            (reset),
        .resp_start       (resp_start),
        .resp_kind        (resp_kind),
        .time_current     (time_current),
        .output_fire_addr (output_fire_addr),
        .metric_addr      (metric_addr),
        .metric_value     (metric_value),
        .tx_packet_rdy    (tx_packet_rdy),
        .tx_packet_data   (tx_packet_data),
        .tx_packet_vld    (tx_packet_vld),
        .resp_done        (resp_done)
    );

endmodule

`default_nettype wire

// File: sim/tb_packet_interface.sv
// Testbench for the host packet link top with a 32-bit network time.
// Each table row is one host operation; the core side is modelled inline.
// tx ready is random, so host-bound packets see back-pressure.
`timescale 1ns/100ps
`default_nettype none

module tb_packet_interface;

    localparam int TIME_W  = ucaspian_link_pkg::TIME_W_DEFAULT;
    localparam int NROWS   = 10;
    localparam int RST_CYC = 16;
    localparam int LIMIT   = 200 * NROWS + RST_CYC;

    // row kinds
    localparam int K_FIRE    = 0;
    localparam int K_STEP    = 1;
    localparam int K_TIME    = 2;
    localparam int K_OFIRE   = 3;
    localparam int K_METRIC  = 4;
    localparam int K_CLR_ACT = 5;
    localparam int K_CLR_CFG = 6;
    localparam int K_DROP    = 7;

    // command bytes, expected core-side values, time input, expected host packet
    int          row_kind [NROWS] = '{K_FIRE, K_STEP, K_TIME, K_OFIRE, K_METRIC,
                                      K_CLR_ACT, K_CLR_CFG, K_DROP, K_METRIC, K_FIRE};
    logic [7:0]  row_b0   [NROWS] = '{8'hA5, 8'h01, 8'h00, 8'h6B, 8'h02,
                                      8'h04, 8'h05, 8'h33, 8'h02, 8'hFF};
    logic [7:0]  row_b1   [NROWS] = '{8'h3C, 8'h07, 8'h00, 8'h00, 8'h21,
                                      8'h00, 8'h00, 8'h00, 8'hC4, 8'h81};
    logic [7:0]  exp_v0   [NROWS] = '{8'h25, 8'h07, 8'h00, 8'h00, 8'h21,
                                      8'h00, 8'h00, 8'h00, 8'hC4, 8'h7F};
    logic [7:0]  exp_v1   [NROWS] = '{8'h3C, 8'h00, 8'h00, 8'h00, 8'h00,
                                      8'h00, 8'h00, 8'h00, 8'h00, 8'h81};
    logic [31:0] row_time [NROWS] = '{32'h0, 32'h0, 32'hDEADBEEF, 32'h0, 32'h0,
                                      32'h0, 32'h0, 32'h0, 32'h0, 32'h0};
    int          exp_len  [NROWS] = '{0, 0, 5, 2, 3, 1, 1, 0, 3, 0};
    // packet bytes left aligned with the header in the top byte
    logic [39:0] exp_pkt  [NROWS] = '{40'h0, 40'h0, 40'h01DEADBEEF, 40'h806B000000,
                                      40'h02217B0000, 40'h0400000000, 40'h0400000000,
                                      40'h0, 40'h02C49E0000, 40'h0};

    logic              clk = 1'b0;
    logic              reset;
    logic              core_active;
    logic              ack_sent;
    logic              led;
    logic              clear_act;
    logic              clear_config;
    logic              clear_done;
    logic              time_remaining;
    logic [TIME_W-1:0] time_current;
    logic              time_update;
    logic              time_sent;
    logic [7:0]        time_target_value;
    logic              time_target_waiting;
    logic              time_target_ack;
    logic [7:0]        output_fire_addr;
    logic              output_fire_waiting;
    logic              output_fire_sent;
    logic [7:0]        input_fire_addr;
    logic [7:0]        input_fire_value;
    logic              input_fire_waiting;
    logic              input_fire_ack;
    logic [7:0]        metric_addr;
    logic [7:0]        metric_value;
    logic              metric_read;
    logic              metric_send;
    logic [7:0]        rx_packet_data;
    logic              rx_packet_vld;
    logic              rx_packet_rdy;
    logic [7:0]        tx_packet_data;
    logic              tx_packet_vld;
    logic              tx_packet_rdy = 1'b0;

    logic [31:0] lcg_state = 32'd23;
    logic [7:0]  tx_seen [$];
    int          tx_rd = 0;
    int          rx_taken = 0;
    int          time_sent_cnt = 0;
    int          fire_sent_cnt = 0;
    int          ack_sent_cnt = 0;
    int          cycle_cnt = 0;

    packet_interface #(
        .TIME_W (TIME_W)
    ) UUT (
        .clk                 (clk),
        .reset               (reset),
        .core_active         (core_active),
        .ack_sent            (ack_sent),
        .led                 (led),
        .clear_act           (clear_act),
        .clear_config        (clear_config),
        .clear_done          (clear_done),
        .time_remaining      (time_remaining),
        .time_current        (time_current),
        .time_update         (time_update),
        .time_sent           (time_sent),
        .time_target_value   (time_target_value),
        .time_target_waiting (time_target_waiting),
        .time_target_ack     (time_target_ack),
        .output_fire_addr    (output_fire_addr),
        .output_fire_waiting (output_fire_waiting),
        .output_fire_sent    (output_fire_sent),
        .input_fire_addr     (input_fire_addr),
        .input_fire_value    (input_fire_value),
        .input_fire_waiting  (input_fire_waiting),
        .input_fire_ack      (input_fire_ack),
        .metric_addr         (metric_addr),
        .metric_value        (metric_value),
        .metric_read         (metric_read),
        .metric_send         (metric_send),
        .rx_packet_data      (rx_packet_data),
        .rx_packet_vld       (rx_packet_vld),
        .rx_packet_rdy       (rx_packet_rdy),
        .tx_packet_data      (tx_packet_data),
        .tx_packet_vld       (tx_packet_vld),
        .tx_packet_rdy       (tx_packet_rdy)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("mismatch at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "value check failed");
        end
    endtask

    // random host back-pressure
    always @(negedge clk) begin
        lcg_state     = lcg_next(lcg_state);
        tx_packet_rdy = lcg_state[16];
    end

    // link monitor and cycle limit
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", LIMIT);
            $display("*** TEST FAILED ***");
            $fatal(1, "timeout");
        end else if (!reset) begin
            if (tx_packet_vld && tx_packet_rdy) begin
                tx_seen.push_back(tx_packet_data);
            end
            if (rx_packet_vld && rx_packet_rdy) begin
                rx_taken = rx_taken + 1;
            end
            time_sent_cnt = time_sent_cnt + int'(time_sent);
            fire_sent_cnt = fire_sent_cnt + int'(output_fire_sent);
            ack_sent_cnt  = ack_sent_cnt + int'(ack_sent);
            if (time_remaining) begin
                check_value(rx_packet_rdy, 0, "rx_packet_rdy while time_remaining");
            end
        end
    end

    // called on a falling edge, returns on the falling edge after the byte is taken
    task automatic send_byte(input logic [7:0] b);
        int n;
        n              = rx_taken;
        rx_packet_data = b;
        rx_packet_vld  = 1'b1;
        while (rx_taken == n) @(negedge clk);
        rx_packet_vld = 1'b0;
    endtask

    task automatic check_packet(input int r);
        int i;
        check_value(tx_seen.size() - tx_rd, exp_len[r], $sformatf("row %0d tx length", r));
        for (i = 0; i < exp_len[r]; i++) begin
            check_value(tx_seen[tx_rd + i], exp_pkt[r][39 - 8*i -: 8],
                        $sformatf("row %0d tx byte %0d", r, i));
        end
        tx_rd = tx_rd + exp_len[r];
    endtask

    task automatic run_input_fire(input int r);
        send_byte(row_b0[r]);
        send_byte(row_b1[r]);
        while (!input_fire_waiting) @(negedge clk);
        repeat (3) begin
            check_value(input_fire_waiting, 1, "input_fire_waiting held");
            check_value(input_fire_addr, exp_v0[r], "input_fire_addr");
            check_value(input_fire_value, exp_v1[r], "input_fire_value");
            @(negedge clk);
        end
        input_fire_ack = 1'b1;
        @(negedge clk);
        input_fire_ack = 1'b0;
        check_value(input_fire_waiting, 0, "input_fire_waiting after ack");
    endtask

    task automatic run_step(input int r);
        send_byte(row_b0[r]);
        send_byte(row_b1[r]);
        while (!time_target_waiting) @(negedge clk);
        repeat (3) begin
            check_value(time_target_waiting, 1, "time_target_waiting held");
            check_value(time_target_value, exp_v0[r], "time_target_value");
            @(negedge clk);
        end
        time_target_ack = 1'b1;
        @(negedge clk);
        time_target_ack = 1'b0;
        check_value(time_target_waiting, 0, "time_target_waiting after ack");
    endtask

    task automatic run_time_report(input int r);
        // the monitor checks that host bytes stay held off while a step runs
        time_remaining = 1'b1;
        core_active    = 1'b1;
        repeat (6) @(negedge clk);
        time_remaining = 1'b0;
        core_active    = 1'b0;
        time_current   = row_time[r];
        time_update    = 1'b1;
        while (!time_sent) @(negedge clk);
        time_update = 1'b0;
    endtask

    task automatic run_output_fire(input int r);
        output_fire_addr    = row_b0[r];
        output_fire_waiting = 1'b1;
        while (!output_fire_sent) @(negedge clk);
        output_fire_waiting = 1'b0;
    endtask

    task automatic run_metric(input int r);
        send_byte(row_b0[r]);
        send_byte(row_b1[r]);
        while (!metric_read) @(negedge clk);
        // core model answers with the address scrambled
        metric_value = metric_addr ^ 8'h5A;
        repeat (3) begin
            check_value(metric_read, 1, "metric_read held");
            check_value(metric_addr, exp_v0[r], "metric_addr");
            @(negedge clk);
        end
        metric_send = 1'b1;
        while (metric_read) @(negedge clk);
        metric_send = 1'b0;
        check_value(tx_seen.size() - tx_rd, exp_len[r], "metric packet out before release");
    endtask

    task automatic run_clear(input int r);
        send_byte(row_b0[r]);
        while (!(clear_act || clear_config)) @(negedge clk);
        check_value(clear_act, row_kind[r] == K_CLR_ACT, "clear_act");
        check_value(clear_config, row_kind[r] == K_CLR_CFG, "clear_config");
        repeat (3) @(negedge clk);
        clear_done = 1'b1;
        while (!ack_sent) @(negedge clk);
        clear_done = 1'b0;
        @(negedge clk);
        check_value(clear_act || clear_config, 0, "clear outputs after ack");
    endtask

    initial begin
        int r;
        int t0;
        int f0;
        int a0;
        reset               = 1'b1;
        core_active         = 1'b0;
        clear_done          = 1'b0;
        time_remaining      = 1'b0;
        time_current        = '0;
        time_update         = 1'b0;
        time_target_ack     = 1'b0;
        output_fire_addr    = 8'h00;
        output_fire_waiting = 1'b0;
        input_fire_ack      = 1'b0;
        metric_value        = 8'h00;
        metric_send         = 1'b0;
        rx_packet_data      = 8'h00;
        rx_packet_vld       = 1'b0;
        repeat (RST_CYC) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        check_value(rx_packet_rdy, 1, "rx_packet_rdy after reset");
        check_value(tx_packet_vld, 0, "tx_packet_vld after reset");
        check_value(led, 1, "led after reset");

        for (r = 0; r < NROWS; r++) begin
            t0 = time_sent_cnt;
            f0 = fire_sent_cnt;
            a0 = ack_sent_cnt;
            case (row_kind[r])
                K_FIRE:   run_input_fire(r);
                K_STEP:   run_step(r);
                K_TIME:   run_time_report(r);
                K_OFIRE:  run_output_fire(r);
                K_METRIC: run_metric(r);
                K_DROP: begin
                    send_byte(row_b0[r]);
                    repeat (3) @(negedge clk);
                    check_value({input_fire_waiting, time_target_waiting, metric_read,
                                 clear_act, clear_config}, 0, "request after unknown opcode");
                end
                default:  run_clear(r);
            endcase
            // quiet gap so a repeated strobe or byte would show up
            repeat (4) @(negedge clk);
            check_value(time_sent_cnt - t0, row_kind[r] == K_TIME, "time_sent strobes");
            check_value(fire_sent_cnt - f0, row_kind[r] == K_OFIRE, "output_fire_sent strobes");
            check_value(ack_sent_cnt - a0,
                        (row_kind[r] == K_CLR_ACT) || (row_kind[r] == K_CLR_CFG),
                        "ack_sent strobes");
            check_packet(r);
            check_value(led, 1, $sformatf("row %0d parser idle", r));
        end
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: ucaspian_link.f
hdl/ucaspian_link_pkg.sv
hdl/packet_rx_parser.sv
hdl/tx_response_select.sv
hdl/tx_serializer.sv
hdl/packet_interface.sv
sim/tb_packet_interface.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tb_packet_interface
FILELIST  := ucaspian_link.f
VFLAGS    := --binary --assert -Wno-fatal -j 0
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# exit status of the simulator is the test result
run: compile
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)
